//--- design/icache_geom_pkg.sv
// Instruction cache geometry
// 8 ways, 64 sets, 64-byte lines, and the address field types derived from them
`default_nettype none

package icache_geom_pkg;

  localparam int unsigned WAYS           = 8;
  localparam int unsigned SETS           = 64;
  localparam int unsigned WORDS_PER_LINE = 8;

  // Address split: tag [63:12], index [11:6], word [5:3]
  localparam int unsigned LINE_OFF_W     = 6;
  localparam int unsigned WORD_OFF_W     = 3;
  localparam int unsigned INDEX_W        = 6;
  localparam int unsigned TAG_W          = 52;

  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;
  typedef logic [2:0]            way_t;

  // All tags of one set, way 0 in the low bits
  typedef logic [WAYS-1:0][TAG_W-1:0] tag_row_t;
  typedef logic [WAYS-1:0]            way_mask_t;

endpackage

`default_nettype wire

//--- design/icache_bus_pkg.sv
// Fetch-side and memory-bus widths
// Shared by the front end, the refill engine and the data array
`default_nettype none

package icache_bus_pkg;

  localparam int unsigned ADDR_W  = 64;
  localparam int unsigned DATA_W  = 64;
  localparam int unsigned INSTR_W = 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

//--- design/icache_sram.sv
// Generic storage array
// Combinational read port and one write port on the clock edge
`default_nettype none

module icache_sram #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2,
  localparam int unsigned AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic          clk_i,
  input  logic          we_i,
  input  logic [AW-1:0] waddr_i,
  input  payload_t      wdata_i,
  input  logic [AW-1:0] raddr_i,
  output payload_t      rdata_o
);

  payload_t mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[raddr_i];

endmodule

`default_nettype wire

//--- design/icache_tag_store.sv
// Tag store with per-way valid bits
// Detects the invalidate edge, writes a tag on refill completion and
// compares all eight ways against the lookup tag
`default_nettype none

module icache_tag_store (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      invalidate_all_i,
  input  logic                      refill_idle_i,
  input  icache_geom_pkg::index_t   index_i,
  input  icache_geom_pkg::tag_t     lookup_tag_i,
  input  logic                      set_valid_i,
  input  icache_geom_pkg::way_t     way_i,
  input  icache_geom_pkg::tag_t     new_tag_i,
  output logic                      hit_o,
  output icache_geom_pkg::way_t     hit_way_o,
  output icache_geom_pkg::way_mask_t valid_ways_o
);

  logic [icache_geom_pkg::SETS-1:0][icache_geom_pkg::WAYS-1:0] valid_q;
  logic                                                      inv_seen_q;
  logic                                                      inv_pulse;
  icache_geom_pkg::tag_row_t                                 tag_row_rd;
  icache_geom_pkg::tag_row_t                                 tag_row_wr;

  icache_sram #(
    .payload_t (icache_geom_pkg::tag_row_t),
    .DEPTH     (icache_geom_pkg::SETS)
  ) tag_sram_i (
    .clk_i   (clk_i),
    .we_i    (set_valid_i),
    .waddr_i (index_i),
    .wdata_i (tag_row_wr),
    .raddr_i (index_i),
    .rdata_o (tag_row_rd)
  );

  // Read-modify-write of the row, only the refilled way changes
  always_comb begin
    tag_row_wr        = tag_row_rd;
    tag_row_wr[way_i] = new_tag_i;
  end

  // Rising edge of the invalidate level
  assign inv_pulse = invalidate_all_i & ~inv_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inv_seen_q <= 1'b0;
      valid_q    <= '0;
    end else begin
      inv_seen_q <= invalidate_all_i;
      if (inv_pulse && refill_idle_i) begin
        valid_q <= '0;
      end else if (set_valid_i) begin
        valid_q[index_i][way_i] <= 1'b1;
      end
    end
  end

  assign valid_ways_o = valid_q[index_i];

  // ----------------------------------------
  // Hit compare, lowest matching way wins
  always_comb begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int w = icache_geom_pkg::WAYS - 1; w >= 0; w--) begin
      if (valid_ways_o[w] && (tag_row_rd[w] == lookup_tag_i)) begin
        hit_o     = 1'b1;
        hit_way_o = icache_geom_pkg::way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icache_plru.sv
// Tree pseudo-LRU replacement
// Seven tree bits per set; invalid ways are filled lowest first
`default_nettype none

module icache_plru (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  icache_geom_pkg::index_t    index_i,
  input  logic                       touch_i,
  input  icache_geom_pkg::way_t      used_way_i,
  input  icache_geom_pkg::way_mask_t valid_ways_i,
  output icache_geom_pkg::way_t      victim_o
);

  // Node 0 is the root, nodes 1-2 the middle level, nodes 3-6 the leaves
  // A bit of 1 sends the victim search to the upper half
  logic [icache_geom_pkg::SETS-1:0][icache_geom_pkg::WAYS-2:0] tree_q;
  logic [icache_geom_pkg::WAYS-2:0]                            tree;
  logic                                                        b2;
  logic                                                        b1;
  logic                                                        b0;

  // Point every level on the path away from the used way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (touch_i) begin
      tree_q[index_i][0]                    <= ~used_way_i[2];
      tree_q[index_i][1 + used_way_i[2]]    <= ~used_way_i[1];
      tree_q[index_i][3 + used_way_i[2:1]]  <= ~used_way_i[0];
    end
  end

  always_comb begin
    tree = tree_q[index_i];
    b2   = tree[0];
    b1   = tree[1 + b2];
    b0   = tree[3 + {b2, b1}];
    victim_o = {b2, b1, b0};
    // An empty way always beats the tree
    for (int w = icache_geom_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_ways_i[w]) begin
        victim_o = icache_geom_pkg::way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icache_refill.sv
// Miss handling and line refill
// Requests the line base, writes eight beats into the victim way and
// steers the array address and the PLRU touch
`default_nettype none

module icache_refill (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lookup_req_i,
  input  icache_bus_pkg::addr_t     lookup_addr_i,
  input  logic                      hit_i,
  input  icache_geom_pkg::way_t     hit_way_i,
  input  icache_geom_pkg::way_t     victim_i,
  input  logic                      gnt_i,
  input  logic                      rvalid_i,
  output logic                      req_o,
  output icache_bus_pkg::addr_t     addr_o,
  output icache_geom_pkg::index_t   arr_index_o,
  output icache_geom_pkg::way_t     arr_way_o,
  output icache_geom_pkg::word_off_t arr_word_o,
  output logic                      arr_we_o,
  output logic                      tag_set_valid_o,
  output icache_geom_pkg::tag_t     pend_tag_o,
  output logic                      plru_touch_o,
  output icache_geom_pkg::way_t     plru_way_o,
  output logic                      refill_idle_o
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_REQ,
    R_STREAM,
    R_RESP
  } state_e;

  state_e                     state_q, state_d;
  icache_geom_pkg::word_off_t beat_q, beat_d;
  logic                       req_q, req_d;
  logic                       touch_q, touch_d;
  icache_geom_pkg::way_t      touch_way_q, touch_way_d;
  logic                       capture;

  icache_geom_pkg::index_t    pend_index_q;
  icache_geom_pkg::tag_t      pend_tag_q;
  icache_geom_pkg::word_off_t pend_word_q;
  icache_geom_pkg::way_t      pend_victim_q;

  icache_geom_pkg::index_t    lk_index;
  icache_geom_pkg::tag_t      lk_tag;
  icache_geom_pkg::word_off_t lk_word;

  assign lk_tag   = lookup_addr_i[icache_bus_pkg::ADDR_W-1 -: icache_geom_pkg::TAG_W];
  assign lk_index = lookup_addr_i[icache_geom_pkg::LINE_OFF_W +: icache_geom_pkg::INDEX_W];
  assign lk_word  = lookup_addr_i[icache_geom_pkg::LINE_OFF_W-1 -: icache_geom_pkg::WORD_OFF_W];

  always_comb begin
    state_d         = state_q;
    beat_d          = beat_q;
    req_d           = req_q;
    touch_d         = 1'b0;
    touch_way_d     = hit_way_i;
    capture         = 1'b0;
    // Array follows the lookup unless a refill owns it
    arr_index_o     = lk_index;
    arr_word_o      = lk_word;
    arr_way_o       = hit_way_i;
    arr_we_o        = 1'b0;
    tag_set_valid_o = 1'b0;

    unique case (state_q)
      R_IDLE: begin
        if (lookup_req_i && hit_i) begin
          touch_d = 1'b1;
        end else if (lookup_req_i) begin
          capture = 1'b1;
          req_d   = 1'b1;
          beat_d  = '0;
          state_d = R_REQ;
        end
      end
      R_REQ: begin
        // Request ends in the granted cycle
        if (gnt_i) begin
          req_d   = 1'b0;
          state_d = R_STREAM;
        end
      end
      R_STREAM: begin
        arr_index_o = pend_index_q;
        arr_word_o  = beat_q;
        arr_way_o   = pend_victim_q;
        if (rvalid_i) begin
          arr_we_o = 1'b1;
          if (beat_q == '1) begin
            tag_set_valid_o = 1'b1;
            state_d         = R_RESP;
          end else begin
            beat_d = beat_q + 1'b1;
          end
        end
      end
      R_RESP: begin
        arr_index_o = pend_index_q;
        arr_word_o  = pend_word_q;
        arr_way_o   = pend_victim_q;
        touch_d     = 1'b1;
        touch_way_d = pend_victim_q;
        state_d     = R_IDLE;
      end
      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= R_IDLE;
      beat_q      <= '0;
      req_q       <= 1'b0;
      touch_q     <= 1'b0;
      touch_way_q <= '0;
    end else begin
      state_q     <= state_d;
      beat_q      <= beat_d;
      req_q       <= req_d;
      touch_q     <= touch_d;
      touch_way_q <= touch_way_d;
    end
  end

  // Miss context
  always_ff @(posedge clk_i) begin
    if (capture) begin
      pend_index_q  <= lk_index;
      pend_tag_q    <= lk_tag;
      pend_word_q   <= lk_word;
      pend_victim_q <= victim_i;
    end
  end

  assign req_o         = req_q;
  assign addr_o        = {pend_tag_q, pend_index_q, {icache_geom_pkg::LINE_OFF_W{1'b0}}};
  assign pend_tag_o    = pend_tag_q;
  assign plru_touch_o  = touch_q;
  assign plru_way_o    = touch_way_q;
  assign refill_idle_o = (state_q == R_IDLE);

endmodule

`default_nettype wire

//--- design/icache_fetch.sv
// Fetch front end
// Grants one request at a time, holds the lookup until it hits and
// registers the selected 32-bit half of the word
`default_nettype none

module icache_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_req_i,
  input  icache_bus_pkg::addr_t  fetch_pc_i,
  output logic                   fetch_gnt_o,
  output logic                   instr_valid_o,
  output icache_bus_pkg::instr_t instr_o,
  input  logic                   refill_idle_i,
  input  logic                   hit_i,
  input  icache_bus_pkg::data_t  rd_data_i,
  output logic                   lookup_req_o,
  output icache_bus_pkg::addr_t  lookup_addr_o
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_WAIT,
    F_RESP
  } state_e;

  state_e                 state_q, state_d;
  icache_bus_pkg::addr_t  pc_q;
  logic                   instr_valid_q;
  icache_bus_pkg::instr_t instr_q;

  assign fetch_gnt_o   = (state_q == F_IDLE) && fetch_req_i;
  assign lookup_req_o  = (state_q == F_WAIT);
  assign lookup_addr_o = {pc_q[icache_bus_pkg::ADDR_W-1:3], 3'b000};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      F_IDLE: if (fetch_req_i) state_d = F_WAIT;
      // A hit only counts once no refill is in flight
      F_WAIT: if (refill_idle_i && hit_i) state_d = F_RESP;
      F_RESP: state_d = F_IDLE;
      default: state_d = F_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= F_IDLE;
      instr_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      instr_valid_q <= (state_q == F_RESP);
    end
  end

  // ----------------------------------------
  // PC capture and instruction select
  always_ff @(posedge clk_i) begin
    if (fetch_gnt_o) begin
      pc_q <= fetch_pc_i;
    end
    if (state_q == F_RESP) begin
      instr_q <= pc_q[2] ? rd_data_i[icache_bus_pkg::DATA_W-1 -: icache_bus_pkg::INSTR_W]
                         : rd_data_i[icache_bus_pkg::INSTR_W-1:0];
    end
  end

  assign instr_valid_o = instr_valid_q;
  assign instr_o       = instr_q;

endmodule

`default_nettype wire

//--- design/icache_top.sv
// Instruction cache top level
// 32 KiB, 8-way, 64-byte lines; refills over a read-only burst bus
`default_nettype none

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   invalidate_all_i,
  input  logic                   fetch_req_i,
  input  icache_bus_pkg::addr_t  fetch_pc_i,
  output logic                   fetch_gnt_o,
  output logic                   instr_valid_o,
  output icache_bus_pkg::instr_t instr_o,
  output logic                   req_o,
  output icache_bus_pkg::addr_t  addr_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  input  icache_bus_pkg::data_t  rdata_i
);

  logic                       lookup_req;
  icache_bus_pkg::addr_t      lookup_addr;
  icache_geom_pkg::index_t    arr_index;
  icache_geom_pkg::way_t      arr_way;
  icache_geom_pkg::word_off_t arr_word;
  logic                       arr_we;
  logic                       tag_set_valid;
  icache_geom_pkg::tag_t      pend_tag;
  logic                       plru_touch;
  icache_geom_pkg::way_t      plru_way;
  logic                       refill_idle;
  logic                       hit;
  icache_geom_pkg::way_t      hit_way;
  icache_geom_pkg::way_mask_t valid_ways;
  icache_geom_pkg::way_t      victim;
  icache_bus_pkg::data_t      rd_data;

  icache_fetch fetch_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_gnt_o   (fetch_gnt_o),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .refill_idle_i (refill_idle),
    .hit_i         (hit),
    .rd_data_i     (rd_data),
    .lookup_req_o  (lookup_req),
    .lookup_addr_o (lookup_addr)
  );

  icache_refill refill_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lookup_req_i    (lookup_req),
    .lookup_addr_i   (lookup_addr),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_i        (victim),
    .gnt_i           (gnt_i),
    .rvalid_i        (rvalid_i),
    .req_o           (req_o),
    .addr_o          (addr_o),
    .arr_index_o     (arr_index),
    .arr_way_o       (arr_way),
    .arr_word_o      (arr_word),
    .arr_we_o        (arr_we),
    .tag_set_valid_o (tag_set_valid),
    .pend_tag_o      (pend_tag),
    .plru_touch_o    (plru_touch),
    .plru_way_o      (plru_way),
    .refill_idle_o   (refill_idle)
  );

  icache_tag_store tag_store_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .invalidate_all_i (invalidate_all_i),
    .refill_idle_i    (refill_idle),
    .index_i          (arr_index),
    .lookup_tag_i     (lookup_addr[icache_bus_pkg::ADDR_W-1 -: icache_geom_pkg::TAG_W]),
    .set_valid_i      (tag_set_valid),
    .way_i            (arr_way),
    .new_tag_i        (pend_tag),
    .hit_o            (hit),
    .hit_way_o        (hit_way),
    .valid_ways_o     (valid_ways)
  );

  icache_plru plru_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .index_i      (arr_index),
    .touch_i      (plru_touch),
    .used_way_i   (plru_way),
    .valid_ways_i (valid_ways),
    .victim_o     (victim)
  );

  // Data array, one 64-bit word per {set, way, word}
  icache_sram #(
    .payload_t (icache_bus_pkg::data_t),
    .DEPTH     (icache_geom_pkg::SETS * icache_geom_pkg::WAYS *
                icache_geom_pkg::WORDS_PER_LINE)
  ) data_sram_i (
    .clk_i   (clk_i),
    .we_i    (arr_we),
    .waddr_i ({arr_index, arr_way, arr_word}),
    .wdata_i (rdata_i),
    .raddr_i ({arr_index, arr_way, arr_word}),
    .rdata_o (rd_data)
  );

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
// Testbench for the instruction cache
// Randomized memory latency, directed fetch sequences and immediate assertions
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TIMEOUT = 400;
  localparam logic [31:0] HI_KEY  = 32'h5a5a_0f0f;
  localparam icache_geom_pkg::tag_t TAG_COLD = 52'h8_0000_0001_2345;
  localparam icache_geom_pkg::tag_t TAG_SET  = 52'h0_00ab_c000_0100;

  logic                   clk;
  logic                   rst_n;
  logic                   invalidate_all;
  logic                   fetch_req;
  icache_bus_pkg::addr_t  fetch_pc;
  logic                   fetch_gnt;
  logic                   instr_valid;
  icache_bus_pkg::instr_t instr;
  logic                   req;
  icache_bus_pkg::addr_t  addr;
  logic                   gnt;
  logic                   rvalid;
  icache_bus_pkg::data_t  rdata;

  // Bookkeeping updated by the memory model
  int unsigned            req_count;
  icache_bus_pkg::addr_t  last_req_addr;
  time                    last_beat_at;

  icache_top dut_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .invalidate_all_i (invalidate_all),
    .fetch_req_i      (fetch_req),
    .fetch_pc_i       (fetch_pc),
    .fetch_gnt_o      (fetch_gnt),
    .instr_valid_o    (instr_valid),
    .instr_o          (instr),
    .req_o            (req),
    .addr_o           (addr),
    .gnt_i            (gnt),
    .rvalid_i         (rvalid),
    .rdata_i          (rdata)
  );

  always #2 clk = ~clk;

  task automatic value_error(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "value check failed");
  endtask

  task automatic wait_expired(input string what);
    $display("Timed out at %0d ns waiting for %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "wait limit exceeded");
  endtask

  // Low half is the word address, high half the same bits XOR a key
  function automatic icache_bus_pkg::data_t mem_word(input icache_bus_pkg::addr_t a);
    return {a[31:0] ^ HI_KEY, a[31:0]};
  endfunction

  function automatic icache_bus_pkg::instr_t expected_instr(input icache_bus_pkg::addr_t pc);
    logic [31:0] base;
    base = {pc[31:3], 3'b000};
    return pc[2] ? (base ^ HI_KEY) : base;
  endfunction

  function automatic icache_bus_pkg::addr_t make_pc(input icache_geom_pkg::tag_t tag,
                                                   input icache_geom_pkg::index_t idx,
                                                   input icache_geom_pkg::word_off_t word,
                                                   input logic upper);
    return {tag, idx, word, upper, 2'b00};
  endfunction

  // ----------------------------------------
  // Memory model
  task automatic serve_line();
    icache_bus_pkg::addr_t base;
    int                    wait_cycles;
    base        = addr;
    wait_cycles = int'($urandom_range(3, 0));
    for (int i = 0; i < wait_cycles; i++) begin
      @(negedge clk);
      assert (req && addr == base) else value_error("req_o or addr_o changed before grant");
    end
    gnt           = 1'b1;
    req_count     = req_count + 1;
    last_req_addr = base;
    @(negedge clk);
    gnt = 1'b0;
    for (int beat = 0; beat < 8; beat++) begin
      wait_cycles = int'($urandom_range(2, 0));
      for (int i = 0; i < wait_cycles; i++) begin
        @(negedge clk);
      end
      assert (!req) else value_error("req_o still high after grant");
      rvalid = 1'b1;
      rdata  = mem_word(base + 64'(beat * 8));
      @(negedge clk);
      rvalid = 1'b0;
    end
    last_beat_at = $time;
  endtask

  always begin
    @(negedge clk);
    if (rst_n && req) begin
      serve_line();
    end
  end

  // ----------------------------------------
  // One fetch checked for data, request count and timing
  task automatic fetch_and_check(input icache_bus_pkg::addr_t pc, input logic expect_miss);
    int unsigned            reqs_before;
    int                     n;
    logic                   granted;
    logic                   saw_req;
    time                    valid_at;
    icache_bus_pkg::instr_t got;
    reqs_before = req_count;
    granted     = 1'b0;
    saw_req     = 1'b0;
    for (int i = 0; i < TIMEOUT && !granted; i++) begin
      @(negedge clk);
      fetch_req = 1'b1;
      fetch_pc  = pc;
      #1;
      granted = fetch_gnt;
    end
    if (!granted) wait_expired("fetch_gnt_o");
    // n counts falling edges after the granting edge
    n = 0;
    @(negedge clk);
    fetch_req = 1'b0;
    while (!instr_valid) begin
      if (n >= TIMEOUT) wait_expired("instr_valid_o");
      saw_req = saw_req | req;
      @(negedge clk);
      n++;
      if (expect_miss && n == 1) begin
        assert (req) else value_error("req_o not raised after the first lookup");
      end
    end
    got      = instr;
    valid_at = $time;
    @(negedge clk);
    assert (!instr_valid) else value_error("instr_valid_o longer than one cycle");
    assert (got == expected_instr(pc))
      else value_error($sformatf("pc %h gave %h, expected %h", pc, got, expected_instr(pc)));
    if (expect_miss) begin
      assert (req_count == reqs_before + 1) else value_error("miss did not issue one request");
      assert (last_req_addr == {pc[63:6], 6'b0})
        else value_error($sformatf("request address %h for pc %h", last_req_addr, pc));
      // The eighth beat is followed by one response cycle and the two-cycle hit path
      assert (valid_at - last_beat_at == 12)
        else value_error($sformatf("instr_valid_o %0d ns after the last beat, expected 12",
                                   valid_at - last_beat_at));
    end else begin
      assert (!saw_req && req_count == reqs_before)
        else value_error($sformatf("hit at pc %h raised req_o", pc));
      assert (n == 2) else value_error($sformatf("hit latency %0d, expected 2", n));
    end
  endtask

  initial begin
    icache_bus_pkg::addr_t pc_cold;
    void'($urandom(32'hb27035f2));
    clk            = 1'b0;
    rst_n          = 1'b0;
    invalidate_all = 1'b0;
    fetch_req      = 1'b0;
    fetch_pc       = '0;
    gnt            = 1'b0;
    rvalid         = 1'b0;
    rdata          = '0;
    req_count      = 0;
    last_req_addr  = '0;
    last_beat_at   = 0;
    repeat (16) @(negedge clk);
    assert (!req && !instr_valid) else value_error("outputs active in reset");
    rst_n = 1'b1;

    // Cold miss followed by hits in the same line and both halves of one word
    pc_cold = make_pc(TAG_COLD, 6'd5, 3'd3, 1'b1);
    fetch_and_check(pc_cold, 1'b1);
    fetch_and_check(make_pc(TAG_COLD, 6'd5, 3'd6, 1'b0), 1'b0);
    fetch_and_check(make_pc(TAG_COLD, 6'd5, 3'd1, 1'b0), 1'b0);
    fetch_and_check(make_pc(TAG_COLD, 6'd5, 3'd1, 1'b1), 1'b0);

    // Fill set 20 and touch all ways in order so the tree points at way 0
    for (int k = 0; k < 8; k++) begin
      fetch_and_check(make_pc(TAG_SET + icache_geom_pkg::tag_t'(k), 6'd20,
                              icache_geom_pkg::word_off_t'(k), k[0]), 1'b1);
    end
    for (int k = 0; k < 8; k++) begin
      fetch_and_check(make_pc(TAG_SET + icache_geom_pkg::tag_t'(k), 6'd20,
                              icache_geom_pkg::word_off_t'(k), k[0]), 1'b0);
    end
    fetch_and_check(make_pc(TAG_SET + 52'd8, 6'd20, 3'd2, 1'b1), 1'b1);
    for (int k = 1; k < 8; k++) begin
      fetch_and_check(make_pc(TAG_SET + icache_geom_pkg::tag_t'(k), 6'd20,
                              icache_geom_pkg::word_off_t'(7 - k), k[1]), 1'b0);
    end
    fetch_and_check(make_pc(TAG_SET, 6'd20, 3'd4, 1'b0), 1'b1);

    // The cold line misses again after an invalidate while idle
    @(negedge clk);
    invalidate_all = 1'b1;
    repeat (2) @(negedge clk);
    invalidate_all = 1'b0;
    fetch_and_check(pc_cold, 1'b1);
    fetch_and_check(make_pc(TAG_COLD, 6'd5, 3'd0, 1'b0), 1'b0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/icache_geom_pkg.sv
design/icache_bus_pkg.sv
design/icache_sram.sv
design/icache_tag_store.sv
design/icache_plru.sv
design/icache_refill.sv
design/icache_fetch.sv
design/icache_top.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module icache_tb -o icache_tb_sim \
  && ./obj_dir/icache_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
